// File: rtl/fetch_consts.svh
// shared widths and reset pc for the fetch front end, include before any package or module use
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

`default_nettype none

// core datapath widths
`define PC_WD         32  // byte address of one instruction
`define INST_WD       32  // no compressed instructions

// instruction sram port
`define SRAM_ADDR_WD  32  // byte address, 8-byte aligned on the port
`define SRAM_DATA_WD  64  // two instructions per read word

// first instruction fetched after reset
`define PC_RESETVAL   32'h8000_0000

// pc_gen resets its register one step below PC_RESETVAL
// so that the first sequential next pc lands on it

`default_nettype wire

`endif

// File: rtl/core_pkg.sv
// pipeline types passed between core stages, imported by fetch and later stages
`include "fetch_consts.svh"

`default_nettype none

package core_pkg;

  // byte address of one instruction
  typedef logic [`PC_WD-1:0] pc_t;

  // one fetched instruction word
  typedef logic [`INST_WD-1:0] inst_t;

  // sequential step between instructions, fixed 4 bytes
  localparam pc_t PC_STEP = `PC_WD'(4);

  // NOTE: a wider pc would need the sram address width raised to match,
  // pc_gen drives the address straight from the next pc

endpackage : core_pkg

`default_nettype wire

// File: rtl/isram_pkg.sv
// types of the instruction sram read port, imported by the fetch front end and its testbench
`include "fetch_consts.svh"

`default_nettype none

package isram_pkg;

  typedef logic [`SRAM_ADDR_WD-1:0] isram_addr_t;  // byte address
  typedef logic [`SRAM_DATA_WD-1:0] isram_data_t;  // one read word

  // which 32-bit half of the read word holds the instruction, follows pc bit 2
  typedef enum logic {
    LOWER = 1'b0,
    UPPER = 1'b1
  } isram_half_e;

endpackage : isram_pkg

`default_nettype wire

// File: rtl/pc_gen.sv
// pre-fetch stage: holds the fetch pc, picks the next pc and issues the instruction sram read
`include "fetch_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module pc_gen
  import core_pkg::*;
  import isram_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  // branch from decode
  input  logic        i_br_stall,        // branch not resolved yet
  input  logic        i_br_sel,          // one-cycle redirect pulse
  input  pc_t         i_br_target,
  // from fetch stage
  input  logic        i_fs_allowin,
  // to fetch stage
  output logic        o_fetch_req,
  output pc_t         o_pc,              // pc of the word fetch holds
  // inst sram read
  output logic        o_inst_sram_ren,
  output isram_addr_t o_inst_sram_addr
);

  logic boot_done;  // low during reset and the cycle after
  pc_t  pc_q;
  pc_t  seq_pc;
  pc_t  next_pc;
  logic pc_load;

  // first request goes out one cycle after reset is released
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      boot_done <= 1'b0;
    end else begin
      boot_done <= 1'b1;
    end
  end

  assign o_fetch_req = boot_done && !i_br_stall;  // stall wins over redirect

  assign seq_pc  = pc_q + PC_STEP;
  assign next_pc = i_br_sel ? i_br_target : seq_pc;

  // a read is issued only when fetch can take the returning word
  assign pc_load = o_fetch_req && i_fs_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_q <= `PC_RESETVAL - PC_STEP;  // first next pc is the reset pc
    end else if (pc_load) begin
      pc_q <= next_pc;  // now names the word coming back next cycle
    end
  end

  assign o_pc = pc_q;

  // sram word is 64 bits, so drop the byte offset within it
  assign o_inst_sram_ren  = pc_load;
  assign o_inst_sram_addr = {next_pc[`SRAM_ADDR_WD-1:3], 3'b000};

endmodule : pc_gen

`default_nettype wire

// File: rtl/fetch_stage.sv
// fetch stage that holds the valid bit and selects the 32-bit instruction, instantiated by fetch_unit
`include "fetch_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import core_pkg::*;
  import isram_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  // from pre-fetch
  input  logic        i_fetch_req,
  input  pc_t         i_pc,
  // from decode
  input  logic        i_ds_allowin,
  // inst sram word returned one cycle after the read
  input  isram_data_t i_inst_sram_rdata,
  // to pre-fetch
  output logic        o_fs_allowin,
  // to decode
  output logic        o_fs_to_ds_valid,
  output inst_t       o_fs_inst,
  output pc_t         o_fs_pc
);

  logic        fs_valid;
  isram_half_e inst_half;
  inst_t       inst_lo;
  inst_t       inst_hi;

  // stage is empty, or its word leaves for decode this cycle
  assign o_fs_allowin = !fs_valid || i_ds_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      fs_valid <= 1'b0;
    end else if (o_fs_allowin) begin
      fs_valid <= i_fetch_req;  // bubble on branch stall
    end
  end

  assign o_fs_to_ds_valid = fs_valid;

  // the sram holds its read data while ren is low
  // which keeps the word steady under back-pressure
  assign inst_lo = i_inst_sram_rdata[`INST_WD-1:0];
  assign inst_hi = i_inst_sram_rdata[`SRAM_DATA_WD-1 -: `INST_WD];

  // pc bit 2 picks the half of the 8-byte word
  assign inst_half = isram_half_e'(i_pc[2]);

  always_comb begin
    case (inst_half)
      UPPER:   o_fs_inst = inst_hi;
      default: o_fs_inst = inst_lo;
    endcase
  end

  // pre-fetch loads its pc only with a new read
  // so it already names the word held here
  assign o_fs_pc = i_pc;

endmodule : fetch_stage

`default_nettype wire

// File: rtl/fetch_unit.sv
// fetch front end top: joins pre-fetch and fetch stage to the branch, decode and inst sram ports
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
  import core_pkg::*;
  import isram_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  // branch bus from decode
  input  logic        i_br_stall,
  input  logic        i_br_sel,
  input  pc_t         i_br_target,
  // decode handshake
  input  logic        i_ds_allowin,
  output logic        o_fs_to_ds_valid,
  output inst_t       o_fs_inst,
  output pc_t         o_fs_pc,
  // inst sram interface
  output logic        o_inst_sram_ren,
  output isram_addr_t o_inst_sram_addr,
  input  isram_data_t i_inst_sram_rdata
);

  logic fs_allowin;  // fetch stage can take a new word
  logic fetch_req;   // pre-fetch has a request
  pc_t  fetch_pc;    // pc of the word in fetch

  // pre-fetch, next pc and sram read
  pc_gen u_pc_gen (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_br_stall       (i_br_stall),
    .i_br_sel         (i_br_sel),
    .i_br_target      (i_br_target),
    .i_fs_allowin     (fs_allowin),
    .o_fetch_req      (fetch_req),
    .o_pc             (fetch_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  // fetch stage, holds the returned word toward decode
  fetch_stage u_fetch_stage (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_fetch_req       (fetch_req),
    .i_pc              (fetch_pc),
    .i_ds_allowin      (i_ds_allowin),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_fs_allowin      (fs_allowin),
    .o_fs_to_ds_valid  (o_fs_to_ds_valid),
    .o_fs_inst         (o_fs_inst),
    .o_fs_pc           (o_fs_pc)
  );

endmodule : fetch_unit

`default_nettype wire

// File: dv/fetch_unit_chk.sv
// concurrent checks on the fetch front end, bound into fetch_unit by the testbench
`include "fetch_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module fetch_unit_chk
  import core_pkg::*;
  import isram_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_br_stall,
  input  logic        i_br_sel,
  input  pc_t         i_br_target,
  input  logic        i_ds_allowin,
  input  logic        i_fs_allowin,  // internal fetch stage allowin
  input  logic        i_fs_valid,
  input  inst_t       i_fs_inst,
  input  pc_t         i_fs_pc,
  input  logic        i_sram_ren,
  input  isram_addr_t i_sram_addr,
  input  isram_data_t i_sram_rdata
);

  int   err_cnt = 0;  // failed assertions so far
  logic xfer;
  logic seen_valid;   // first valid instruction already shown
  logic track_q;      // at least one transfer since reset
  pc_t  nxt_pc_q;     // pc expected for the next valid instruction

  assign xfer = i_fs_valid && i_ds_allowin;

  // word the sram model returns for one instruction address
  function automatic inst_t expected_inst(input pc_t pc);
    return {pc[15:0], ~pc[15:0]};
  endfunction

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      seen_valid <= 1'b0;
      track_q    <= 1'b0;
      nxt_pc_q   <= '0;
    end else begin
      if (i_fs_valid) begin
        seen_valid <= 1'b1;
      end
      if (xfer) begin
        track_q  <= 1'b1;
        // stall wins over a redirect pulse
        nxt_pc_q <= (i_br_sel && !i_br_stall) ? i_br_target : i_fs_pc + `PC_WD'(4);
      end
    end
  end

  a_reset_quiet: assert property (@(posedge i_clk)
    !i_rst_n |=> !i_fs_valid && !i_sram_ren)
    else begin
      err_cnt++;
      $error("mismatch at %0t: valid or ren high around reset", $time);
    end

  a_first_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_fs_valid && !seen_valid |-> i_fs_pc == `PC_RESETVAL)
    else begin
      err_cnt++;
      $error("mismatch at %0t: first pc is %h", $time, i_fs_pc);
    end

  a_inst_select: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_fs_valid |-> i_fs_inst == expected_inst(i_fs_pc))
    else begin
      err_cnt++;
      $error("mismatch at %0t: inst %h at pc %h", $time, i_fs_inst, i_fs_pc);
    end

  // covers sequential pc+4, redirect target and resume after stall
  a_next_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_fs_valid && track_q |-> i_fs_pc == nxt_pc_q)
    else begin
      err_cnt++;
      $error("mismatch at %0t: pc %h, want %h", $time, i_fs_pc, nxt_pc_q);
    end

  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_fs_valid && !i_ds_allowin |-> !i_sram_ren ##1
      (i_fs_valid && $stable(i_fs_pc) && $stable(i_fs_inst) && $stable(i_sram_rdata)))
    else begin
      err_cnt++;
      $error("mismatch at %0t: fetch output moved under back-pressure", $time);
    end

  a_redirect_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_sel && !i_br_stall && xfer |-> i_sram_addr == {i_br_target[`PC_WD-1:3], 3'b000})
    else begin
      err_cnt++;
      $error("mismatch at %0t: redirect addr %h", $time, i_sram_addr);
    end

  a_redirect_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_sel && !i_br_stall && xfer |=> i_fs_valid && i_fs_pc == $past(i_br_target))
    else begin
      err_cnt++;
      $error("mismatch at %0t: redirect pc %h", $time, i_fs_pc);
    end

  a_stall_no_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_stall |-> !i_sram_ren)
    else begin
      err_cnt++;
      $error("mismatch at %0t: sram read during branch stall", $time);
    end

  a_stall_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_stall && i_fs_allowin |=> !i_fs_valid)
    else begin
      err_cnt++;
      $error("mismatch at %0t: valid after stalled cycle", $time);
    end

endmodule : fetch_unit_chk

`default_nettype wire

// File: dv/tb_fetch_unit.sv
// top-level testbench that drives fetch_unit and models its instruction sram, run as simulation top
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit
  import core_pkg::*;
  import isram_pkg::*;
();

  localparam int CYCLE_LIMIT = 2000;  // about four times the test length

  logic        clk;
  logic        rst_n;
  logic        br_stall;
  logic        br_sel;
  pc_t         br_target;
  logic        ds_allowin;
  logic        fs_valid;
  inst_t       fs_inst;
  pc_t         fs_pc;
  logic        sram_ren;
  isram_addr_t sram_addr;
  isram_data_t sram_rdata = '0;
  isram_addr_t rd_addr;

  integer seed;
  int     cycles = 0;
  int     xfer_cnt = 0;
  int     tb_errs = 0;
  int     tests_run = 0;
  int     errs_at_start;
  int     xfers_at_start;

  fetch_unit dut_i (
    .i_clk             (clk),
    .i_rst_n           (rst_n),
    .i_br_stall        (br_stall),
    .i_br_sel          (br_sel),
    .i_br_target       (br_target),
    .i_ds_allowin      (ds_allowin),
    .o_fs_to_ds_valid  (fs_valid),
    .o_fs_inst         (fs_inst),
    .o_fs_pc           (fs_pc),
    .o_inst_sram_ren   (sram_ren),
    .o_inst_sram_addr  (sram_addr),
    .i_inst_sram_rdata (sram_rdata)
  );

  bind fetch_unit fetch_unit_chk chk_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_br_stall   (i_br_stall),
    .i_br_sel     (i_br_sel),
    .i_br_target  (i_br_target),
    .i_ds_allowin (i_ds_allowin),
    .i_fs_allowin (fs_allowin),
    .i_fs_valid   (o_fs_to_ds_valid),
    .i_fs_inst    (o_fs_inst),
    .i_fs_pc      (o_fs_pc),
    .i_sram_ren   (o_inst_sram_ren),
    .i_sram_addr  (o_inst_sram_addr),
    .i_sram_rdata (i_inst_sram_rdata)
  );

  function automatic inst_t inst_word(input isram_addr_t a);
    return {a[15:0], ~a[15:0]};
  endfunction

  // word at a+4 in the upper half
  function automatic isram_data_t sram_line(input isram_addr_t a);
    return {inst_word(a + 4), inst_word(a)};
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // synchronous sram that holds its data while ren is low
  always @(posedge clk) begin
    if (sram_ren) begin
      rd_addr = sram_addr;  // still the value of the ending cycle
      #1 sram_rdata = sram_line(rd_addr);
    end
  end

  always @(posedge clk) begin
    if (rst_n && fs_valid && ds_allowin) begin
      xfer_cnt++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic next_cycle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_for_valid(input int max_cycles);
    int waited;
    waited = 0;
    while (!fs_valid && waited < max_cycles) begin
      next_cycle(1);
      waited++;
    end
    if (!fs_valid) begin
      $display("error at %0t: no valid instruction within %0d cycles", $time, max_cycles);
      tb_errs++;
    end
  endtask

  task automatic start_test();
    errs_at_start  = dut_i.chk_i.err_cnt + tb_errs;
    xfers_at_start = xfer_cnt;
  endtask

  task automatic end_test(input string name);
    int errs;
    int xfers;
    errs  = dut_i.chk_i.err_cnt + tb_errs - errs_at_start;
    xfers = xfer_cnt - xfers_at_start;
    if (xfers == 0) begin
      $display("error: test %s made no transfers to decode", name);
      tb_errs++;
      errs++;
    end
    tests_run++;
    $display("test %s %s transfers %0d errors %0d", name,
             (errs == 0) ? "ok" : "failed", xfers, errs);
  endtask

  initial begin
    pc_t targets [4];
    int  i;
    int  total_errs;
    rst_n      = 1'b0;
    br_stall   = 1'b0;
    br_sel     = 1'b0;
    br_target  = '0;
    ds_allowin = 1'b0;
    seed       = 32'hb9ad;
    targets    = '{32'h8000_1004, 32'h8000_2000, 32'h8000_300c, 32'h8000_0ff8};

    start_test();
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    ds_allowin = 1'b1;
    wait_for_valid(10);
    next_cycle(1);
    end_test("reset");

    start_test();
    next_cycle(40);
    end_test("sequential");

    start_test();
    repeat (300) begin
      ds_allowin = ($random(seed) & 32'h1) != 0;
      next_cycle(1);
    end
    ds_allowin = 1'b1;
    next_cycle(2);
    end_test("backpressure");

    // pulse only on a cycle that transfers
    start_test();
    for (i = 0; i < 4; i++) begin
      wait_for_valid(10);
      br_sel    = 1'b1;
      br_target = targets[i];
      next_cycle(1);
      br_sel = 1'b0;
      next_cycle(5);
    end
    end_test("redirect");

    start_test();
    for (i = 0; i < 3; i++) begin
      wait_for_valid(10);
      br_stall   = 1'b1;
      ds_allowin = (i != 1);  // middle round stalls under back-pressure
      next_cycle(2);
      ds_allowin = 1'b1;
      next_cycle(2 + i);
      br_stall = 1'b0;
      next_cycle(6);
    end
    end_test("stall");

    total_errs = dut_i.chk_i.err_cnt + tb_errs;
    $display("summary: %0d tests, %0d transfers, %0d errors", tests_run, xfer_cnt, total_errs);
    if (total_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_fetch_unit

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/core_pkg.sv
rtl/isram_pkg.sv
rtl/pc_gen.sv
rtl/fetch_stage.sv
rtl/fetch_unit.sv
dv/fetch_unit_chk.sv
dv/tb_fetch_unit.sv

// File: Bender.yml
package:
  name: fetch_unit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/isram_pkg.sv
      - rtl/pc_gen.sv
      - rtl/fetch_stage.sv
      - rtl/fetch_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/fetch_unit_chk.sv
      - dv/tb_fetch_unit.sv
